/* busDatapath.f */
logic/busDatapathPkg.sv
logic/busSelect.sv
logic/registerFile.sv
logic/specialRegisters.sv
logic/aluUnit.sv
logic/resultStore.sv
logic/busDatapath.sv
test/busDatapathTb.sv

/* Makefile */
SIM = obj_dir/busDatapathSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f busDatapath.f \
		--top-module busDatapathTb -Mdir obj_dir -o busDatapathSim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* test/busDatapathTb.sv */
// testbench for the single-bus datapath that plays the control sequence step by step
// table rows load operands through MDR, run the ALU and read the result back over the bus
`timescale 1ns/1ps
`default_nettype none

module busDatapathTb;

    localparam int w = busDatapathPkg::wordWidth;
    localparam int rowCount = 16;
    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;
    // a multiply or divide row takes about 12 cycles and the limit doubles that
    localparam int timeoutNs = rowCount * 12 * clockPeriod * 2 + resetCycles * clockPeriod;

    typedef struct packed {
        int op;
        int regA;
        int regB;
        int dest;
        bit keepA; // use what regA already holds
        bit randA;
        bit randB;
        logic [w-1:0] valA;
        logic [w-1:0] valB;
    } rowEntry;

    logic Clock;
    logic rstN;
    logic [busDatapathPkg::gprCount-1:0] gprIn;
    logic [busDatapathPkg::gprCount-1:0] gprOut;
    logic pcIn;
    logic irIn;
    logic marIn;
    logic ryIn;
    logic mdrIn;
    logic hiIn;
    logic loIn;
    logic zIn;
    logic pcOut;
    logic mdrOut;
    logic hiOut;
    logic loOut;
    logic zHighOut;
    logic zLowOut;
    logic read;
    logic [busDatapathPkg::aluOpCount-1:0] aluOp;
    logic [w-1:0] mData;
    logic [w-1:0] bus;
    logic [w-1:0] marValue;
    logic [w-1:0] irValue;
    logic [2*w-1:0] zValue;

    rowEntry rowTable [rowCount];
    logic [w-1:0] gprModel [busDatapathPkg::gprCount]; // expected register contents
    integer seed;
    int checks;
    int errors;

    busDatapath uut (
        .Clock(Clock), .rstN(rstN), .gprIn(gprIn), .gprOut(gprOut),
        .pcIn(pcIn), .irIn(irIn), .marIn(marIn), .ryIn(ryIn), .mdrIn(mdrIn),
        .hiIn(hiIn), .loIn(loIn), .zIn(zIn), .pcOut(pcOut), .mdrOut(mdrOut),
        .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .read(read), .aluOp(aluOp), .mData(mData),
        .bus(bus), .marValue(marValue), .irValue(irValue), .zValue(zValue)
    );

    always #(clockPeriod / 2) Clock = ~Clock;

    task automatic nextCycle();
        @(posedge Clock);
        #5;
    endtask

    task automatic clearStrobes();
        gprIn = '0;
        gprOut = '0;
        pcIn = 1'b0;
        irIn = 1'b0;
        marIn = 1'b0;
        ryIn = 1'b0;
        mdrIn = 1'b0;
        hiIn = 1'b0;
        loIn = 1'b0;
        zIn = 1'b0;
        pcOut = 1'b0;
        mdrOut = 1'b0;
        hiOut = 1'b0;
        loOut = 1'b0;
        zHighOut = 1'b0;
        zLowOut = 1'b0;
        read = 1'b0;
        aluOp = '0;
    endtask

    task automatic checkWord(input string name, input logic [2*w-1:0] got,
                             input logic [2*w-1:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // all observed outputs read zero with no strobe high
    task automatic checkCleared();
        checkWord("bus", {{w{1'b0}}, bus}, '0);
        checkWord("marValue", {{w{1'b0}}, marValue}, '0);
        checkWord("irValue", {{w{1'b0}}, irValue}, '0);
        checkWord("zValue", zValue, '0);
    endtask

    // memory word into MDR, then MDR onto the bus into the register
    task automatic loadRegister(input int idx, input logic [w-1:0] value);
        read = 1'b1;
        mdrIn = 1'b1;
        mData = value;
        nextCycle();
        clearStrobes();
        mdrOut = 1'b1;
        gprIn[idx] = 1'b1;
        nextCycle();
        clearStrobes();
        gprModel[idx] = value;
    endtask

    // expected 64-bit Z for A from RY and B from the bus
    function automatic logic [2*w-1:0] expectedResult(input int op, input logic [w-1:0] a,
                                                      input logic [w-1:0] b);
        logic [w-1:0] low;
        int s;
        longint sa;
        longint sb;
        longint quo;
        longint rem;
        low = '0;
        s = int'(b[busDatapathPkg::shiftBits-1:0]);
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            busDatapathPkg::opAdd: low = a + b;
            busDatapathPkg::opSub: low = a - b;
            busDatapathPkg::opAnd: low = a & b;
            busDatapathPkg::opOr: low = a | b;
            busDatapathPkg::opNeg: low = ~b + 32'd1;
            busDatapathPkg::opNot: low = ~b;
            busDatapathPkg::opShl: low = a << s;
            busDatapathPkg::opShr: low = a >> s; // zero fill
            busDatapathPkg::opIncPc: low = b + 32'd1;
            busDatapathPkg::opRol: begin
                low = a;
                for (int k = 0; k < s; k++) begin
                    low = {low[w-2:0], low[w-1]};
                end
            end
            busDatapathPkg::opRor: begin
                low = a;
                for (int k = 0; k < s; k++) begin
                    low = {low[0], low[w-1:1]};
                end
            end
            busDatapathPkg::opMul: return sa * sb;
            busDatapathPkg::opDiv: begin
                if (b == '0) begin
                    return {a, {w{1'b1}}};
                end
                quo = sa / sb;
                rem = sa % sb;
                return {rem[w-1:0], quo[w-1:0]};
            end
            default: low = '0;
        endcase
        return {{w{1'b0}}, low};
    endfunction

    task automatic runRow(input int idx);
        rowEntry r;
        logic [w-1:0] a;
        logic [w-1:0] b;
        logic [2*w-1:0] expected;
        r = rowTable[idx];
        a = r.randA ? $random(seed) : r.valA;
        b = r.randB ? $random(seed) : r.valB;
        if (r.keepA) begin
            a = gprModel[r.regA];
        end else begin
            loadRegister(r.regA, a);
        end
        loadRegister(r.regB, b);
        expected = expectedResult(r.op, a, b);
        gprOut[r.regA] = 1'b1;
        ryIn = 1'b1;
        nextCycle();
        clearStrobes();
        gprOut[r.regB] = 1'b1;
        aluOp[r.op] = 1'b1;
        zIn = 1'b1;
        nextCycle();
        clearStrobes();
        checkWord("zValue", zValue, expected);
        zLowOut = 1'b1;
        gprIn[r.dest] = 1'b1;
        nextCycle();
        clearStrobes();
        gprModel[r.dest] = expected[w-1:0];
        gprOut[r.dest] = 1'b1;
        #10;
        checkWord("bus", {{w{1'b0}}, bus}, {{w{1'b0}}, gprModel[r.dest]});
        nextCycle();
        clearStrobes();
        if (r.op == busDatapathPkg::opMul || r.op == busDatapathPkg::opDiv) begin
            zHighOut = 1'b1;
            hiIn = 1'b1;
            nextCycle();
            clearStrobes();
            zLowOut = 1'b1;
            loIn = 1'b1;
            nextCycle();
            clearStrobes();
            hiOut = 1'b1;
            #10;
            checkWord("bus", {{w{1'b0}}, bus}, {{w{1'b0}}, expected[2*w-1:w]});
            nextCycle();
            clearStrobes();
            loOut = 1'b1;
            #10;
            checkWord("bus", {{w{1'b0}}, bus}, {{w{1'b0}}, expected[w-1:0]});
            nextCycle();
            clearStrobes();
        end
    endtask

    // PC to MAR with increment, Z to PC, memory word through MDR to IR
    task automatic runFetch(input logic [w-1:0] pcStart, input logic [w-1:0] word);
        read = 1'b1;
        mdrIn = 1'b1;
        mData = pcStart;
        nextCycle();
        clearStrobes();
        mdrOut = 1'b1;
        pcIn = 1'b1;
        nextCycle();
        clearStrobes();
        pcOut = 1'b1;
        marIn = 1'b1;
        aluOp[busDatapathPkg::opIncPc] = 1'b1;
        zIn = 1'b1;
        nextCycle();
        clearStrobes();
        zLowOut = 1'b1;
        pcIn = 1'b1;
        nextCycle();
        clearStrobes();
        read = 1'b1;
        mdrIn = 1'b1;
        mData = word;
        nextCycle();
        clearStrobes();
        mdrOut = 1'b1;
        irIn = 1'b1;
        nextCycle();
        clearStrobes();
        checkWord("marValue", {{w{1'b0}}, marValue}, {{w{1'b0}}, pcStart});
        checkWord("irValue", {{w{1'b0}}, irValue}, {{w{1'b0}}, word});
        pcOut = 1'b1;
        #10;
        checkWord("bus", {{w{1'b0}}, bus}, {{w{1'b0}}, pcStart + 32'd1});
        nextCycle();
        clearStrobes();
    endtask

    task automatic buildTable();
        rowTable[0] = '{busDatapathPkg::opAdd, 1, 2, 3, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[1] = '{busDatapathPkg::opSub, 2, 3, 4, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[2] = '{busDatapathPkg::opAnd, 5, 6, 5, 1'b0, 1'b1, 1'b1, '0, '0};
        // R5 again now holding the previous AND result
        rowTable[3] = '{busDatapathPkg::opAnd, 5, 6, 5, 1'b1, 1'b0, 1'b1, '0, '0};
        rowTable[4] = '{busDatapathPkg::opOr, 7, 8, 9, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[5] = '{busDatapathPkg::opNeg, 1, 2, 10, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[6] = '{busDatapathPkg::opNot, 3, 4, 11, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[7] = '{busDatapathPkg::opShl, 4, 5, 12, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[8] = '{busDatapathPkg::opShr, 6, 7, 13, 1'b0, 1'b0, 1'b1, 32'h8000_00F0, '0};
        rowTable[9] = '{busDatapathPkg::opRol, 8, 9, 14, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[10] = '{busDatapathPkg::opRor, 9, 10, 15, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[11] = '{busDatapathPkg::opMul, 1, 2, 3, 1'b0, 1'b0, 1'b0,
                         32'hFFFF_FFF9, 32'h0001_E240};
        rowTable[12] = '{busDatapathPkg::opMul, 4, 5, 6, 1'b0, 1'b1, 1'b1, '0, '0};
        rowTable[13] = '{busDatapathPkg::opDiv, 7, 8, 9, 1'b0, 1'b0, 1'b0,
                         32'hFFFF_FF9C, 32'h0000_0007};
        rowTable[14] = '{busDatapathPkg::opDiv, 10, 11, 12, 1'b0, 1'b0, 1'b0,
                         32'h0000_3039, 32'h0000_0000}; // divide by zero
        rowTable[15] = '{busDatapathPkg::opDiv, 13, 14, 0, 1'b0, 1'b1, 1'b1, '0, '0};
    endtask

    initial begin
        seed = 71810;
        checks = 0;
        errors = 0;
        Clock = 1'b0;
        rstN = 1'b0;
        mData = '0;
        clearStrobes();
        for (int i = 0; i < busDatapathPkg::gprCount; i++) begin
            gprModel[i] = '0;
        end
        buildTable();
        repeat (resetCycles) @(posedge Clock);
        #5;
        rstN = 1'b1;
        #10;
        checkCleared(); // nothing driving the bus yet
        nextCycle();
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end
        runFetch(32'h0000_0040, 32'hA5C3_1E07);
        // reset again while MAR, IR and Z hold the fetch values
        rstN = 1'b0;
        nextCycle();
        rstN = 1'b1;
        #10;
        checkCleared();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: the run did not finish within %0d ns", timeoutNs);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/busDatapath.sv */
// single-bus datapath top, strobes come straight from the control sequence
// exposes the bus and a few registers for observation
`timescale 1ns/1ps
`default_nettype none

module busDatapath (
    input logic Clock,
    input logic rstN,
    input logic [busDatapathPkg::gprCount-1:0] gprIn,
    input logic [busDatapathPkg::gprCount-1:0] gprOut,
    input logic pcIn,
    input logic irIn,
    input logic marIn,
    input logic ryIn,
    input logic mdrIn,
    input logic hiIn,
    input logic loIn,
    input logic zIn,
    input logic pcOut,
    input logic mdrOut,
    input logic hiOut,
    input logic loOut,
    input logic zHighOut,
    input logic zLowOut,
    input logic read,
    input logic [busDatapathPkg::aluOpCount-1:0] aluOp,
    input logic [busDatapathPkg::wordWidth-1:0] mData,
    output logic [busDatapathPkg::wordWidth-1:0] bus,
    output logic [busDatapathPkg::wordWidth-1:0] marValue,
    output logic [busDatapathPkg::wordWidth-1:0] irValue,
    output logic [2*busDatapathPkg::wordWidth-1:0] zValue
);

    logic [busDatapathPkg::wordWidth-1:0] gprValues [busDatapathPkg::gprCount];
    logic [busDatapathPkg::wordWidth-1:0] pcValue;
    logic [busDatapathPkg::wordWidth-1:0] mdrValue;
    logic [busDatapathPkg::wordWidth-1:0] ryValue;
    logic [busDatapathPkg::wordWidth-1:0] hiValue;
    logic [busDatapathPkg::wordWidth-1:0] loValue;
    logic [2*busDatapathPkg::wordWidth-1:0] aluResult;

    busSelect busSel (
        .Clock(Clock), .gprOut(gprOut), .pcOut(pcOut), .mdrOut(mdrOut),
        .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .gprValues(gprValues), .pcValue(pcValue), .mdrValue(mdrValue),
        .hiValue(hiValue), .loValue(loValue), .zValue(zValue), .bus(bus)
    );

    registerFile gprs (
        .Clock(Clock), .rstN(rstN), .gprIn(gprIn), .bus(bus), .gprValues(gprValues)
    );

    specialRegisters specials (
        .Clock(Clock), .rstN(rstN), .bus(bus), .mData(mData), .read(read),
        .pcIn(pcIn), .irIn(irIn), .marIn(marIn), .ryIn(ryIn), .mdrIn(mdrIn),
        .pcValue(pcValue), .irValue(irValue), .marValue(marValue),
        .ryValue(ryValue), .mdrValue(mdrValue)
    );

    aluUnit alu (
        .aluOp(aluOp), .ryValue(ryValue), .bus(bus), .aluResult(aluResult)
    );

    // Z, HI, LO
    resultStore results (
        .Clock(Clock), .rstN(rstN), .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
        .aluResult(aluResult), .bus(bus), .aluOp(aluOp),
        .zValue(zValue), .hiValue(hiValue), .loValue(loValue)
    );

endmodule

`default_nettype wire

/* logic/resultStore.sv */
// Z holds the 64-bit ALU result, HI and LO load from the bus
// Z halves go back onto the bus through busSelect
`timescale 1ns/1ps
`default_nettype none

module resultStore (
    input logic Clock,
    input logic rstN,
    input logic zIn,
    input logic hiIn,
    input logic loIn,
    input logic [2*busDatapathPkg::wordWidth-1:0] aluResult,
    input logic [busDatapathPkg::wordWidth-1:0] bus,
    input logic [busDatapathPkg::aluOpCount-1:0] aluOp,
    output logic [2*busDatapathPkg::wordWidth-1:0] zValue,
    output logic [busDatapathPkg::wordWidth-1:0] hiValue,
    output logic [busDatapathPkg::wordWidth-1:0] loValue
);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            zValue <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (zIn) begin
                zValue <= aluResult;
            end
            if (hiIn) begin
                hiValue <= bus;
            end
            if (loIn) begin
                loValue <= bus;
            end
        end
    end

    // Z is only meaningful when the ALU was told exactly one thing to do
    zLoadOneOp: assert property (
        @(posedge Clock) disable iff (!rstN)
        zIn |-> $onehot(aluOp)
    ) else $error("zIn with aluOp not one-hot");

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
// combinational ALU, A is RY and B is the bus
// result is always 64 bits, only multiply and divide use the high word
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input logic [busDatapathPkg::aluOpCount-1:0] aluOp,
    input logic [busDatapathPkg::wordWidth-1:0] ryValue,
    input logic [busDatapathPkg::wordWidth-1:0] bus,
    output logic [2*busDatapathPkg::wordWidth-1:0] aluResult
);

    localparam int w = busDatapathPkg::wordWidth;

    logic [w-1:0] opA;
    logic [w-1:0] opB;
    logic [busDatapathPkg::shiftBits-1:0] shamt;
    logic [2*w-1:0] product;
    logic [w-1:0] quotient;
    logic [w-1:0] remainder;
    logic [2*w-1:0] rorWide;
    logic [2*w-1:0] rolWide;
    logic [w-1:0] lowWord;

    assign opA = ryValue;
    assign opB = bus;
    assign shamt = opB[busDatapathPkg::shiftBits-1:0];

    // signed 32x32 product
    assign product = $signed({{w{opA[w-1]}}, opA}) * $signed({{w{opB[w-1]}}, opB});

    // divide by zero gives all ones and leaves A as the remainder
    always_comb begin
        if (opB == '0) begin
            quotient = '1;
            remainder = opA;
        end else begin
            quotient = $signed(opA) / $signed(opB);
            remainder = $signed(opA) % $signed(opB);
        end
    end

    // rotate through a doubled copy of A
    assign rorWide = {opA, opA} >> shamt;
    assign rolWide = {opA, opA} << shamt;

    // single word results
    always_comb begin
        lowWord = '0;
        case (1'b1)
            aluOp[busDatapathPkg::opAdd]: lowWord = opA + opB;
            aluOp[busDatapathPkg::opSub]: lowWord = opA - opB;
            aluOp[busDatapathPkg::opShr]: lowWord = opA >> shamt;
            aluOp[busDatapathPkg::opShl]: lowWord = opA << shamt;
            aluOp[busDatapathPkg::opRor]: lowWord = rorWide[w-1:0];
            aluOp[busDatapathPkg::opRol]: lowWord = rolWide[2*w-1:w];
            aluOp[busDatapathPkg::opAnd]: lowWord = opA & opB;
            aluOp[busDatapathPkg::opOr]: lowWord = opA | opB;
            aluOp[busDatapathPkg::opNeg]: lowWord = -opB;
            aluOp[busDatapathPkg::opNot]: lowWord = ~opB;
            aluOp[busDatapathPkg::opIncPc]: lowWord = opB + 1'b1; // next PC
            default: lowWord = '0;
        endcase
    end

    // multiply and divide fill both halves
    always_comb begin
        if (aluOp[busDatapathPkg::opMul]) begin
            aluResult = product;
        end else if (aluOp[busDatapathPkg::opDiv]) begin
            aluResult = {remainder, quotient};
        end else begin
            aluResult = {{w{1'b0}}, lowWord};
        end
    end

endmodule

`default_nettype wire

/* logic/specialRegisters.sv */
// PC, IR, MAR, RY and MDR
// MDR takes the memory word while read is high, the bus otherwise
`timescale 1ns/1ps
`default_nettype none

module specialRegisters (
    input logic Clock,
    input logic rstN,
    input logic [busDatapathPkg::wordWidth-1:0] bus,
    input logic [busDatapathPkg::wordWidth-1:0] mData,
    input logic read,
    input logic pcIn,
    input logic irIn,
    input logic marIn,
    input logic ryIn,
    input logic mdrIn,
    output logic [busDatapathPkg::wordWidth-1:0] pcValue,
    output logic [busDatapathPkg::wordWidth-1:0] irValue,
    output logic [busDatapathPkg::wordWidth-1:0] marValue,
    output logic [busDatapathPkg::wordWidth-1:0] ryValue,
    output logic [busDatapathPkg::wordWidth-1:0] mdrValue
);

    logic [busDatapathPkg::wordWidth-1:0] mdrNext;

    assign mdrNext = read ? mData : bus; // memory read path into MDR

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcValue <= '0;
            irValue <= '0;
            marValue <= '0;
        end else begin
            if (pcIn) begin
                pcValue <= bus;
            end
            if (irIn) begin
                irValue <= bus; // fetched word arrives via MDR on the bus
            end
            if (marIn) begin
                marValue <= bus;
            end
        end
    end

    // operand A latch for the ALU
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            ryValue <= '0;
        end else if (ryIn) begin
            ryValue <= bus;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    // a memory read with no MDR load would drop the fetched word
    readNeedsMdrIn: assert property (
        @(posedge Clock) disable iff (!rstN)
        read |-> mdrIn
    ) else $error("read high without mdrIn");

endmodule

`default_nettype wire

/* logic/registerFile.sv */
// general purpose registers, each loads the bus on its own in strobe
// several registers may take the same bus value in one cycle
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input logic Clock,
    input logic rstN,
    input logic [busDatapathPkg::gprCount-1:0] gprIn,
    input logic [busDatapathPkg::wordWidth-1:0] bus,
    output logic [busDatapathPkg::wordWidth-1:0] gprValues [busDatapathPkg::gprCount]
);

    genvar i;

    // one flop bank per register
    generate
        for (i = 0; i < busDatapathPkg::gprCount; i++) begin : gprBank
            logic [busDatapathPkg::wordWidth-1:0] regQ;

            always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                    regQ <= '0;
                end else if (gprIn[i]) begin
                    regQ <= bus;
                end
            end

            assign gprValues[i] = regQ;
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/busSelect.sv */
// shared bus driver: the one out strobe that is high picks the source
// an idle bus reads as zero
`timescale 1ns/1ps
`default_nettype none

module busSelect (
    input logic Clock,
    input logic [busDatapathPkg::gprCount-1:0] gprOut,
    input logic pcOut,
    input logic mdrOut,
    input logic hiOut,
    input logic loOut,
    input logic zHighOut,
    input logic zLowOut,
    input logic [busDatapathPkg::wordWidth-1:0] gprValues [busDatapathPkg::gprCount],
    input logic [busDatapathPkg::wordWidth-1:0] pcValue,
    input logic [busDatapathPkg::wordWidth-1:0] mdrValue,
    input logic [busDatapathPkg::wordWidth-1:0] hiValue,
    input logic [busDatapathPkg::wordWidth-1:0] loValue,
    input logic [2*busDatapathPkg::wordWidth-1:0] zValue,
    output logic [busDatapathPkg::wordWidth-1:0] bus
);

    logic [busDatapathPkg::wordWidth-1:0] gprBus;
    logic [busDatapathPkg::wordWidth-1:0] specialBus;

    // and-or tree over the register file, no priority between entries
    always_comb begin
        gprBus = '0;
        for (int i = 0; i < busDatapathPkg::gprCount; i++) begin
            if (gprOut[i]) begin
                gprBus = gprBus | gprValues[i];
            end
        end
    end

    always_comb begin
        specialBus = '0;
        if (pcOut) begin
            specialBus = specialBus | pcValue;
        end
        if (mdrOut) begin
            specialBus = specialBus | mdrValue;
        end
        if (hiOut) begin
            specialBus = specialBus | hiValue;
        end
        if (loOut) begin
            specialBus = specialBus | loValue;
        end
        // Z is 64 bits, each half has its own strobe
        if (zHighOut) begin
            specialBus = specialBus | zValue[2*busDatapathPkg::wordWidth-1:busDatapathPkg::wordWidth];
        end
        if (zLowOut) begin
            specialBus = specialBus | zValue[busDatapathPkg::wordWidth-1:0];
        end
    end

    assign bus = gprBus | specialBus;

    // two drivers at once would OR the sources together
    busSingleDriver: assert property (
        @(posedge Clock)
        $onehot0({gprOut, pcOut, mdrOut, hiOut, loOut, zHighOut, zLowOut})
    ) else $error("more than one bus out strobe high");

endmodule

`default_nettype wire

/* logic/busDatapathPkg.sv */
// shared widths and ALU strobe positions for the single-bus datapath
// every block refers to these by scoped name
`default_nettype none

package busDatapathPkg;

    // datapath word, Z is twice this wide
    localparam int wordWidth = 32;

    // general purpose register file
    localparam int gprCount = 16;
    localparam int gprIndexWidth = 4; // enough bits to name any of gprCount

    // one-hot ALU strobe vector, top bit is spare
    localparam int aluOpCount = 14;

    localparam int opAdd = 0;
    localparam int opSub = 1;
    localparam int opMul = 2; // signed, full 64-bit product
    localparam int opDiv = 3; // signed, quotient low and remainder high
    localparam int opShr = 4; // logical
    localparam int opShl = 5;
    localparam int opRor = 6;
    localparam int opRol = 7;
    localparam int opAnd = 8;
    localparam int opOr = 9;
    localparam int opNeg = 10;
    localparam int opNot = 11;
    localparam int opIncPc = 12;

    // shift and rotate amount is taken from the low bus bits
    localparam int shiftBits = 5;

endpackage

`default_nettype wire
